// ==== Makefile ====
# Verilator build and run of the hazard controller testbench

VERILATOR ?= verilator
TOP       ?= hazard_ctrl_tb
FILELIST  ?= hazard_ctrl_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hazard_ctrl_top.f ====
+incdir+tests
verilog/hazard_pkg.sv
verilog/stage_wr_if.sv
verilog/stage_writer_decode.sv
verilog/read_port_match.sv
verilog/stall_merge.sv
verilog/hazard_ctrl_top.sv
tests/hazard_ctrl_tb.sv

// ==== tests/hazard_vectors.svh ====
// Directed stimulus vectors with expected outputs for the hazard controller testbench
`ifndef HAZARD_VECTORS_SVH
`define HAZARD_VECTORS_SVH

// Columns: name, id {valid jmpr csr mret wfi}, read enables {port1 port0}, rs port 0, rs port 1
// then ex {valid we lsu csr mret wfi}, ex waddr, wb {valid we lsu csr mret ready}, wb waddr
// and expected {fw0[1:0] fw1[1:0] jalr_sel load_stall jalr_stall csr_stall wfi_stall}
task automatic build_vector_table();
  // Everything idle, every select at the register file
  add_vector("idle", 5'b00000, 2'b00, 5'd0, 5'd0,
             6'b000000, 5'd0, 6'b000001, 5'd0, 9'b00_00_0_0000);
  // Both stages write x5, the younger EX result wins
  add_vector("fw_ex_priority", 5'b10000, 2'b01, 5'd5, 5'd0,
             6'b110000, 5'd5, 6'b110001, 5'd5, 9'b01_00_1_0000);
  add_vector("fw_wb_only", 5'b10000, 2'b10, 5'd3, 5'd7,
             6'b110000, 5'd9, 6'b110001, 5'd7, 9'b00_10_0_0000);
  // x0 never forwards, even when both stages claim to write it
  add_vector("fw_x0_read", 5'b10000, 2'b11, 5'd0, 5'd0,
             6'b110000, 5'd0, 6'b110001, 5'd0, 9'b00_00_0_0000);
  add_vector("fw_re_off", 5'b10000, 2'b00, 5'd4, 5'd4,
             6'b110000, 5'd4, 6'b000001, 5'd0, 9'b00_00_0_0000);
  // Load data is never available in EX
  add_vector("load_use_ex", 5'b10000, 2'b01, 5'd6, 5'd0,
             6'b111000, 5'd6, 6'b000001, 5'd0, 9'b01_00_0_1000);
  add_vector("load_use_wb_wait", 5'b10000, 2'b10, 5'd1, 5'd8,
             6'b000000, 5'd0, 6'b111000, 5'd8, 9'b00_10_0_1000);
  add_vector("load_use_wb_ready", 5'b10000, 2'b10, 5'd1, 5'd8,
             6'b000000, 5'd0, 6'b111001, 5'd8, 9'b00_10_0_0000);
  // JALR base register against EX and WB writers
  add_vector("jalr_ex_alu", 5'b11000, 2'b01, 5'd10, 5'd0,
             6'b110000, 5'd10, 6'b000001, 5'd0, 9'b01_00_0_0100);
  add_vector("jalr_wb_load", 5'b11000, 2'b01, 5'd11, 5'd0,
             6'b000000, 5'd0, 6'b111001, 5'd11, 9'b10_00_1_0100);
  add_vector("jalr_wb_alu", 5'b11000, 2'b01, 5'd12, 5'd0,
             6'b000000, 5'd0, 6'b110001, 5'd12, 9'b10_00_1_0000);
  // CSR readers in ID against CSR writers in EX and WB
  add_vector("csr_id_ex_csr", 5'b10100, 2'b00, 5'd0, 5'd0,
             6'b100100, 5'd0, 6'b000001, 5'd0, 9'b00_00_0_0010);
  add_vector("mret_id_wb_mret", 5'b10010, 2'b00, 5'd0, 5'd0,
             6'b000000, 5'd0, 6'b100011, 5'd0, 9'b00_00_0_0010);
  add_vector("wfi_id_ex_mret", 5'b10001, 2'b00, 5'd0, 5'd0,
             6'b100010, 5'd0, 6'b000001, 5'd0, 9'b00_00_0_0010);
  add_vector("csr_id_invalid", 5'b00100, 2'b00, 5'd0, 5'd0,
             6'b100100, 5'd0, 6'b000001, 5'd0, 9'b00_00_0_0000);
  // WFI in EX, valid and then a bubble
  add_vector("wfi_ex_valid", 5'b00000, 2'b00, 5'd0, 5'd0,
             6'b100001, 5'd0, 6'b000001, 5'd0, 9'b00_00_0_0001);
  add_vector("wfi_ex_invalid", 5'b00000, 2'b00, 5'd0, 5'd0,
             6'b000001, 5'd0, 6'b000001, 5'd0, 9'b00_00_0_0000);
endtask

`endif

// ==== tests/hazard_ctrl_tb.sv ====
// Testbench with clock, reset, directed table loop, LCG random phase, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl_tb import hazard_pkg::*; ();

  localparam int unsigned NUM_PORTS  = 2;
  localparam int unsigned NUM_RANDOM = 200;
  localparam int unsigned MAX_CYCLES = 1000;

  // One stimulus row, flags packed in the same order as the table columns
  typedef struct {
    string      name;
    logic [4:0] id_f;
    logic [1:0] re;
    rf_addr_t   ra0;
    rf_addr_t   ra1;
    logic [5:0] ex_f;
    rf_addr_t   ex_wa;
    logic [5:0] wb_f;
    rf_addr_t   wb_wa;
    logic [8:0] exp_o;
  } vec_t;

  vec_t        vectors [$];
  int unsigned error_count;
  int unsigned check_count;
  logic [31:0] lcg_state;

  logic clk;
  logic rst_n_i;

  // DUT stimulus and responses
  logic                 id_valid, alu_jmpr, csr_en_raw, sys_mret, sys_wfi;
  logic [NUM_PORTS-1:0] rf_re;
  rf_addr_t             raddr [NUM_PORTS];
  logic                 ex_valid, ex_rf_we, ex_lsu_en, ex_csr_en, ex_sys_mret, ex_sys_wfi;
  rf_addr_t             ex_rf_waddr;
  logic                 wb_valid, wb_rf_we, wb_lsu_en, wb_csr_en, wb_sys_mret, wb_ready;
  rf_addr_t             wb_rf_waddr;
  op_fw_sel_e           fw_sel [NUM_PORTS];
  jalr_fw_sel_e         jalr_sel;
  logic                 load_stall, jalr_stall, csr_stall, wfi_stall;

  hazard_ctrl_top #(
    .NUM_READ_PORTS (NUM_PORTS)
  ) u_hazard_ctrl_top (
    .id_valid_i       (id_valid),
    .rf_re_id_i       (rf_re),
    .rf_raddr_id_i    (raddr),
    .alu_jmpr_id_i    (alu_jmpr),
    .csr_en_raw_id_i  (csr_en_raw),
    .sys_mret_id_i    (sys_mret),
    .sys_wfi_id_i     (sys_wfi),
    .ex_valid_i       (ex_valid),
    .ex_rf_we_i       (ex_rf_we),
    .ex_rf_waddr_i    (ex_rf_waddr),
    .ex_lsu_en_i      (ex_lsu_en),
    .ex_csr_en_i      (ex_csr_en),
    .ex_sys_mret_i    (ex_sys_mret),
    .ex_sys_wfi_i     (ex_sys_wfi),
    .wb_valid_i       (wb_valid),
    .wb_rf_we_i       (wb_rf_we),
    .wb_rf_waddr_i    (wb_rf_waddr),
    .wb_lsu_en_i      (wb_lsu_en),
    .wb_csr_en_i      (wb_csr_en),
    .wb_sys_mret_i    (wb_sys_mret),
    .wb_ready_i       (wb_ready),
    .operand_fw_sel_o (fw_sel),
    .jalr_fw_sel_o    (jalr_sel),
    .load_stall_o     (load_stall),
    .jalr_stall_o     (jalr_stall),
    .csr_stall_o      (csr_stall),
    .wfi_stall_o      (wfi_stall)
  );

  initial begin : p_clk
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic add_vector(input string name, input logic [4:0] id_f, input logic [1:0] re,
                            input rf_addr_t ra0, input rf_addr_t ra1,
                            input logic [5:0] ex_f, input rf_addr_t ex_wa,
                            input logic [5:0] wb_f, input rf_addr_t wb_wa,
                            input logic [8:0] exp_o);
    vec_t v;
    v.name  = name;
    v.id_f  = id_f;
    v.re    = re;
    v.ra0   = ra0;
    v.ra1   = ra1;
    v.ex_f  = ex_f;
    v.ex_wa = ex_wa;
    v.wb_f  = wb_f;
    v.wb_wa = wb_wa;
    v.exp_o = exp_o;
    vectors.push_back(v);
  endtask

  `include "hazard_vectors.svh"

  // Classic 32 bit LCG, only the upper half is used since its low bits repeat quickly
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic vec_t random_vector(input int unsigned idx);
    vec_t        v;
    logic [31:0] r1;
    logic [31:0] r2;
    r1      = next_rand();
    r2      = next_rand();
    v.name  = $sformatf("random_%0d", idx);
    v.id_f  = r1[31:27];
    v.re    = r1[26:25];
    // Addresses stay within x0 to x3 so that hits are frequent
    v.ra0   = {3'b000, r1[24:23]};
    v.ra1   = {3'b000, r1[22:21]};
    v.ex_wa = {3'b000, r1[20:19]};
    v.wb_wa = {3'b000, r1[18:17]};
    v.ex_f  = r2[31:26];
    v.wb_f  = r2[25:20];
    // A WFI has no destination register
    if (v.ex_f[0]) begin
      v.ex_f[4] = 1'b0;
    end
    v.exp_o = model_outputs(v);
    return v;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [8:0] model_outputs(input vec_t v);
    logic [1:0] fw [NUM_PORTS];
    rf_addr_t   ra [NUM_PORTS];
    logic       ex_we, wb_we, ex_ld, wb_ld, ex_use, wb_use;
    logic       jsel, ld_stall, j_stall, c_stall, w_stall;
    ra[0]    = v.ra0;
    ra[1]    = v.ra1;
    ex_we    = v.ex_f[5] && v.ex_f[4];
    wb_we    = v.wb_f[5] && v.wb_f[4];
    ex_ld    = v.ex_f[5] && v.ex_f[3];
    wb_ld    = v.wb_f[5] && v.wb_f[3];
    ld_stall = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      ex_use = v.re[p] && (ra[p] != '0) && ex_we && (ra[p] == v.ex_wa);
      wb_use = v.re[p] && (ra[p] != '0) && wb_we && (ra[p] == v.wb_wa);
      // EX has the youngest value and so beats WB
      fw[p] = ex_use ? 2'b01 : (wb_use ? 2'b10 : 2'b00);
      if ((ex_use && ex_ld) || (wb_use && wb_ld && !v.wb_f[0])) begin
        ld_stall = 1'b1;
      end
    end
    // The JALR path looks at the port 0 address alone, without its read enable
    jsel    = wb_we && (ra[0] != '0) && (ra[0] == v.wb_wa);
    j_stall = v.id_f[4] && v.id_f[3] &&
              ((ex_we && (ra[0] != '0) && (ra[0] == v.ex_wa)) || (jsel && wb_ld));
    c_stall = v.id_f[4] && (|v.id_f[2:0]) &&
              ((v.ex_f[5] && |v.ex_f[2:1]) || (v.wb_f[5] && |v.wb_f[2:1]));
    w_stall = v.ex_f[5] && v.ex_f[0];
    return {fw[0], fw[1], jsel, ld_stall, j_stall, c_stall, w_stall};
  endfunction

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic drive_vector(input vec_t v);
    id_valid    <= v.id_f[4];
    alu_jmpr    <= v.id_f[3];
    csr_en_raw  <= v.id_f[2];
    sys_mret    <= v.id_f[1];
    sys_wfi     <= v.id_f[0];
    rf_re       <= v.re;
    raddr[0]    <= v.ra0;
    raddr[1]    <= v.ra1;
    ex_valid    <= v.ex_f[5];
    ex_rf_we    <= v.ex_f[4];
    ex_lsu_en   <= v.ex_f[3];
    ex_csr_en   <= v.ex_f[2];
    ex_sys_mret <= v.ex_f[1];
    ex_sys_wfi  <= v.ex_f[0];
    ex_rf_waddr <= v.ex_wa;
    wb_valid    <= v.wb_f[5];
    wb_rf_we    <= v.wb_f[4];
    wb_lsu_en   <= v.wb_f[3];
    wb_csr_en   <= v.wb_f[2];
    wb_sys_mret <= v.wb_f[1];
    wb_ready    <= v.wb_f[0];
    wb_rf_waddr <= v.wb_wa;
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [1:0] exp_v, input logic [1:0] act_v);
    check_count++;
    if (exp_v !== act_v) begin
      error_count++;
      $display("error %s %s: expected %0d actual %0d", test, field, exp_v, act_v);
    end
  endtask

  task automatic check_outputs(input string test, input logic [8:0] exp_o);
    check_field(test, "operand_fw_sel_o[0]", exp_o[8:7], fw_sel[0]);
    check_field(test, "operand_fw_sel_o[1]", exp_o[6:5], fw_sel[1]);
    check_field(test, "jalr_fw_sel_o", {1'b0, exp_o[4]}, {1'b0, jalr_sel});
    check_field(test, "load_stall_o", {1'b0, exp_o[3]}, {1'b0, load_stall});
    check_field(test, "jalr_stall_o", {1'b0, exp_o[2]}, {1'b0, jalr_stall});
    check_field(test, "csr_stall_o", {1'b0, exp_o[1]}, {1'b0, csr_stall});
    check_field(test, "wfi_stall_o", {1'b0, exp_o[0]}, {1'b0, wfi_stall});
  endtask

  // Inputs change on the rising edge, outputs are settled by the falling edge
  task automatic run_vector(input vec_t v);
    @(posedge clk);
    drive_vector(v);
    @(negedge clk);
    check_outputs(v.name, v.exp_o);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : p_main
    vec_t        idle;
    int unsigned cycles;
    error_count = 0;
    check_count = 0;
    lcg_state   = 32'd38;
    idle        = '{name: "reset", id_f: '0, re: '0, ra0: '0, ra1: '0, ex_f: '0,
                    ex_wa: '0, wb_f: 6'b000001, wb_wa: '0, exp_o: '0};
    rst_n_i <= 1'b0;
    drive_vector(idle);
    cycles = 0;
    while (cycles < 4) begin
      @(posedge clk);
      cycles++;
    end
    rst_n_i <= 1'b1;
    build_vector_table();
    foreach (vectors[i]) begin
      run_vector(vectors[i]);
    end
    for (int unsigned i = 0; i < NUM_RANDOM; i++) begin
      run_vector(random_vector(i));
    end
    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Bounds the whole run in case the main sequence stops advancing
  initial begin : p_watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule : hazard_ctrl_tb

`default_nettype wire

// ==== verilog/hazard_ctrl_top.sv ====
// Hazard and forwarding controller top level with the decoder, read port matchers and stall merger
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl_top import hazard_pkg::*; #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  // Instruction in ID
  input  logic                      id_valid_i,
  input  logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  rf_addr_t                  rf_raddr_id_i [NUM_READ_PORTS],
  input  logic                      alu_jmpr_id_i,
  input  logic                      csr_en_raw_id_i,
  input  logic                      sys_mret_id_i,
  input  logic                      sys_wfi_id_i,

  // EX pipeline register
  input  logic                      ex_valid_i,
  input  logic                      ex_rf_we_i,
  input  rf_addr_t                  ex_rf_waddr_i,
  input  logic                      ex_lsu_en_i,
  input  logic                      ex_csr_en_i,
  input  logic                      ex_sys_mret_i,
  input  logic                      ex_sys_wfi_i,

  // WB pipeline register
  input  logic                      wb_valid_i,
  input  logic                      wb_rf_we_i,
  input  rf_addr_t                  wb_rf_waddr_i,
  input  logic                      wb_lsu_en_i,
  input  logic                      wb_csr_en_i,
  input  logic                      wb_sys_mret_i,
  input  logic                      wb_ready_i,

  // Forward selects
  output op_fw_sel_e                operand_fw_sel_o [NUM_READ_PORTS],
  output jalr_fw_sel_e              jalr_fw_sel_o,

  // Stalls
  output logic                      load_stall_o,
  output logic                      jalr_stall_o,
  output logic                      csr_stall_o,
  output logic                      wfi_stall_o
);

  //////////////////////////////
  // Stage writers
  //////////////////////////////

  stage_wr_if ex_wr ();
  stage_wr_if wb_wr ();

  stage_writer_decode u_stage_writer_decode (
    .ex_valid_i    (ex_valid_i),
    .ex_rf_we_i    (ex_rf_we_i),
    .ex_rf_waddr_i (ex_rf_waddr_i),
    .ex_lsu_en_i   (ex_lsu_en_i),
    .ex_csr_en_i   (ex_csr_en_i),
    .ex_sys_mret_i (ex_sys_mret_i),
    .ex_sys_wfi_i  (ex_sys_wfi_i),
    .wb_valid_i    (wb_valid_i),
    .wb_rf_we_i    (wb_rf_we_i),
    .wb_rf_waddr_i (wb_rf_waddr_i),
    .wb_lsu_en_i   (wb_lsu_en_i),
    .wb_csr_en_i   (wb_csr_en_i),
    .wb_sys_mret_i (wb_sys_mret_i),
    .ex_wr_o       (ex_wr),
    .wb_wr_o       (wb_wr)
  );

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Per port results, gathered for the stall merger
  // Only port 0 hits feed the JALR path
  logic [NUM_READ_PORTS-1:0] ex_use;
  logic [NUM_READ_PORTS-1:0] wb_use;
  logic [NUM_READ_PORTS-1:0] ex_hit;
  logic [NUM_READ_PORTS-1:0] wb_hit;

  for (genvar gi = 0; gi < NUM_READ_PORTS; gi++) begin : gen_read_port
    read_port_match u_read_port_match (
      .rf_re_i       (rf_re_id_i[gi]),
      .rf_raddr_i    (rf_raddr_id_i[gi]),
      .ex_wr_i       (ex_wr),
      .wb_wr_i       (wb_wr),
      .ex_addr_hit_o (ex_hit[gi]),
      .wb_addr_hit_o (wb_hit[gi]),
      .ex_use_o      (ex_use[gi]),
      .wb_use_o      (wb_use[gi]),
      .fw_sel_o      (operand_fw_sel_o[gi])
    );
  end

  //////////////////////////////
  // Stall merge
  //////////////////////////////

  stall_merge #(
    .NUM_READ_PORTS (NUM_READ_PORTS)
  ) u_stall_merge (
    .ex_use_i        (ex_use),
    .wb_use_i        (wb_use),
    .jalr_ex_hit_i   (ex_hit[0]),
    .jalr_wb_hit_i   (wb_hit[0]),
    .ex_wr_i         (ex_wr),
    .wb_wr_i         (wb_wr),
    .id_valid_i      (id_valid_i),
    .alu_jmpr_id_i   (alu_jmpr_id_i),
    .csr_en_raw_id_i (csr_en_raw_id_i),
    .sys_mret_id_i   (sys_mret_id_i),
    .sys_wfi_id_i    (sys_wfi_id_i),
    .wb_ready_i      (wb_ready_i),
    .load_stall_o    (load_stall_o),
    .jalr_stall_o    (jalr_stall_o),
    .csr_stall_o     (csr_stall_o),
    .wfi_stall_o     (wfi_stall_o),
    .jalr_fw_sel_o   (jalr_fw_sel_o)
  );

endmodule : hazard_ctrl_top

`default_nettype wire

// ==== verilog/hazard_pkg.sv ====
// Register address width, register address type and forward select encodings
`default_nettype none

package hazard_pkg;

  //////////////////////////////
  // Register file addressing
  //////////////////////////////

  // Width of a register file address for the 32 entry integer file
  parameter int unsigned RF_ADDR_W = 5;

  // One register file address as seen by the decoder and the write back path
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  //////////////////////////////
  // Forward select encodings
  //////////////////////////////

  // Source of an operand read in ID
  // The register file is the default when no younger writer matches
  // EX holds the most recent result and therefore wins over WB
  // The encoding 2'b11 is left free for a future operand source
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } op_fw_sel_e;

  // Source of the JALR target base register
  // Only an ALU result in WB may be forwarded to the jump path
  // A load result in WB stalls the JALR instead of being forwarded
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_fw_sel_e;

endpackage : hazard_pkg

`default_nettype wire

// ==== verilog/read_port_match.sv ====
// Read port matcher with address comparison against EX and WB and operand forward select
`timescale 1ns/1ps
`default_nettype none

module read_port_match import hazard_pkg::*; (
  // Read port of the instruction in ID
  input  logic       rf_re_i,
  input  rf_addr_t   rf_raddr_i,

  // Writers in the younger stages
  stage_wr_if.dst    ex_wr_i,
  stage_wr_if.dst    wb_wr_i,

  // Raw address hits, not qualified with any write or read enable
  output logic       ex_addr_hit_o,
  output logic       wb_addr_hit_o,

  // Hits that really consume a result in flight
  output logic       ex_use_o,
  output logic       wb_use_o,

  // Operand source for this port
  output op_fw_sel_e fw_sel_o
);

  // Register x0 is hardwired to zero and is never a dependency
  logic raddr_nonzero;

  assign raddr_nonzero = |rf_raddr_i;

  //////////////////////////////
  // Address comparison
  //////////////////////////////

  // The JALR path relies on the unqualified hit of port 0
  // because a JALR always reads rs1
  assign ex_addr_hit_o = raddr_nonzero && (rf_raddr_i == ex_wr_i.waddr);
  assign wb_addr_hit_o = raddr_nonzero && (rf_raddr_i == wb_wr_i.waddr);

  // A use needs the port to read and the stage to write
  assign ex_use_o = ex_addr_hit_o && rf_re_i && ex_wr_i.wr_en;
  assign wb_use_o = wb_addr_hit_o && rf_re_i && wb_wr_i.wr_en;

  //////////////////////////////
  // Forward select
  //////////////////////////////

  always_comb begin : p_fw_sel
    // EX carries the youngest value of the register
    // so it overrides an older write still sitting in WB
    if (ex_use_o) begin
      fw_sel_o = SEL_FW_EX;
    end else if (wb_use_o) begin
      fw_sel_o = SEL_FW_WB;
    end else begin
      fw_sel_o = SEL_REGFILE;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // A writing stage with an unknown destination would turn every address hit into X
  // and leave the operand source of this port undefined
  always_comb begin : p_waddr_chk
    a_waddr_known : assert final ((!ex_wr_i.wr_en || !$isunknown(ex_wr_i.waddr)) &&
                                  (!wb_wr_i.wr_en || !$isunknown(wb_wr_i.waddr)))
      else $error("a writing stage presents an unknown destination register");
  end

endmodule : read_port_match

`default_nettype wire

// ==== verilog/stage_wr_if.sv ====
// Interface for the qualified writer information of one pipeline stage, with modports
`timescale 1ns/1ps
`default_nettype none

interface stage_wr_if import hazard_pkg::*; ();

  //////////////////////////////
  // Writer information
  //////////////////////////////

  // Register file write, already qualified with the stage valid bit
  logic     wr_en;

  // Destination register of the stage
  // This field is not qualified and must be used together with wr_en
  rf_addr_t waddr;

  // Load or store in the stage, qualified with valid
  logic     load;

  // Explicit CSR access or MRET in the stage, qualified with valid
  // Both of these write CSR state that a younger CSR read may depend on
  logic     csr_wr;

  // WFI in the stage, qualified with valid
  logic     wfi;

  //////////////////////////////
  // Modports
  //////////////////////////////

  // The stage decoder produces every field
  modport src (
    output wr_en,
    output waddr,
    output load,
    output csr_wr,
    output wfi
  );

  // Address matchers and the stall merger only read the fields
  modport dst (
    input  wr_en,
    input  waddr,
    input  load,
    input  csr_wr,
    input  wfi
  );

endinterface : stage_wr_if

`default_nettype wire

// ==== verilog/stage_writer_decode.sv ====
// Stage writer decoder that qualifies raw EX and WB pipeline fields with their valid bits
`timescale 1ns/1ps
`default_nettype none

module stage_writer_decode import hazard_pkg::*; (
  // Raw EX pipeline register fields
  input  logic     ex_valid_i,
  input  logic     ex_rf_we_i,
  input  rf_addr_t ex_rf_waddr_i,
  input  logic     ex_lsu_en_i,
  input  logic     ex_csr_en_i,
  input  logic     ex_sys_mret_i,
  input  logic     ex_sys_wfi_i,

  // Raw WB pipeline register fields
  input  logic     wb_valid_i,
  input  logic     wb_rf_we_i,
  input  rf_addr_t wb_rf_waddr_i,
  input  logic     wb_lsu_en_i,
  input  logic     wb_csr_en_i,
  input  logic     wb_sys_mret_i,

  // Qualified writer information per stage
  stage_wr_if.src  ex_wr_o,
  stage_wr_if.src  wb_wr_o
);

  //////////////////////////////
  // EX stage
  //////////////////////////////

  // A bubble in EX must never look like a writer
  assign ex_wr_o.wr_en  = ex_rf_we_i && ex_valid_i;

  // The address is only meaningful together with wr_en
  assign ex_wr_o.waddr  = ex_rf_waddr_i;

  assign ex_wr_o.load   = ex_lsu_en_i && ex_valid_i;

  // MRET restores mstatus, so it counts as an implicit CSR write
  assign ex_wr_o.csr_wr = (ex_csr_en_i || ex_sys_mret_i) && ex_valid_i;

  assign ex_wr_o.wfi    = ex_sys_wfi_i && ex_valid_i;

  //////////////////////////////
  // WB stage
  //////////////////////////////

  assign wb_wr_o.wr_en  = wb_rf_we_i && wb_valid_i;
  assign wb_wr_o.waddr  = wb_rf_waddr_i;
  assign wb_wr_o.load   = wb_lsu_en_i && wb_valid_i;
  assign wb_wr_o.csr_wr = (wb_csr_en_i || wb_sys_mret_i) && wb_valid_i;

  // Once a WFI has left EX it no longer holds back ID
  assign wb_wr_o.wfi    = 1'b0;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // WFI has no destination register, so a WFI in EX that also writes
  // the register file points at a broken decoder upstream
  always_comb begin : p_wfi_chk
    a_wfi_no_rf_wr : assert final (!(ex_wr_o.wfi && ex_wr_o.wr_en))
      else $error("WFI in EX claims a register file write");
  end

endmodule : stage_writer_decode

`default_nettype wire

// ==== verilog/stall_merge.sv ====
// Stall merger for load, JALR, CSR and WFI stalls and the JALR forward select
`timescale 1ns/1ps
`default_nettype none

module stall_merge import hazard_pkg::*; #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  // Per port results of the read port matchers
  input  logic [NUM_READ_PORTS-1:0] ex_use_i,
  input  logic [NUM_READ_PORTS-1:0] wb_use_i,

  // Raw address hits of port 0, which carries rs1 of a JALR
  input  logic                      jalr_ex_hit_i,
  input  logic                      jalr_wb_hit_i,

  // Writers in the younger stages
  stage_wr_if.dst                   ex_wr_i,
  stage_wr_if.dst                   wb_wr_i,

  // Instruction in ID
  input  logic                      id_valid_i,
  input  logic                      alu_jmpr_id_i,
  input  logic                      csr_en_raw_id_i,
  input  logic                      sys_mret_id_i,
  input  logic                      sys_wfi_id_i,

  // WB waits on the data bus while this is low
  input  logic                      wb_ready_i,

  // Stall requests towards the ID stage
  output logic                      load_stall_o,
  output logic                      jalr_stall_o,
  output logic                      csr_stall_o,
  output logic                      wfi_stall_o,

  // Source of the JALR target base register
  output jalr_fw_sel_e              jalr_fw_sel_o
);

  //////////////////////////////
  // ID qualification
  //////////////////////////////

  logic jmpr_id;
  logic csr_rd_id;
  logic csr_wr_ex_wb;
  logic jalr_wb_fw;

  assign jmpr_id = alu_jmpr_id_i && id_valid_i;

  // WFI reads mstatus.tw and the privilege level, MRET reads mepc
  // so all three count as CSR readers in ID
  assign csr_rd_id = (csr_en_raw_id_i || sys_mret_id_i || sys_wfi_id_i) && id_valid_i;

  assign csr_wr_ex_wb = ex_wr_i.csr_wr || wb_wr_i.csr_wr;

  // WB writes a register that the JALR in ID could take as its base
  assign jalr_wb_fw = wb_wr_i.wr_en && jalr_wb_hit_i;

  //////////////////////////////
  // Stall rules
  //////////////////////////////

  // Load data is not available in EX at all
  // In WB it is only valid once the bus has answered
  assign load_stall_o = (|ex_use_i && ex_wr_i.load) ||
                        (|wb_use_i && wb_wr_i.load && !wb_ready_i);

  // The jump target is computed in ID, so no EX result can reach it in time
  // A load result in WB is kept off the jump path for timing reasons
  assign jalr_stall_o = jmpr_id &&
                        ((ex_wr_i.wr_en && jalr_ex_hit_i) ||
                         (jalr_wb_fw && wb_wr_i.load));

  // Any CSR read in ID waits until older CSR writes have retired
  assign csr_stall_o = csr_rd_id && csr_wr_ex_wb;

  // Keeps loads and stores behind a WFI out of EX
  assign wfi_stall_o = ex_wr_i.wfi;

  //////////////////////////////
  // JALR forward select
  //////////////////////////////

  always_comb begin : p_jalr_fw
    // Don't care when there is no JALR in ID or when it stalls anyway
    if (jalr_wb_fw) begin
      jalr_fw_sel_o = SELJ_FW_WB;
    end else begin
      jalr_fw_sel_o = SELJ_REGFILE;
    end

    // Port 0 carries rs1 of the JALR, so an operand forward from WB on port 0
    // must show up in the JALR select as well
    a_jalr_wb_port0 : assert final (!wb_use_i[0] || (jalr_fw_sel_o == SELJ_FW_WB))
      else $error("port 0 forwards from WB while the JALR select stays at the register file");
  end

endmodule : stall_merge

`default_nettype wire
